/* logic/fpga_4mb_pkg.sv */
// register map, widths, bus structs and link states shared by all motor board RTL; import with ::*
package fpga_4mb_pkg;

	//////////////////////////////////////////////////
	// widths with a meaning
	//////////////////////////////////////////////////
	typedef logic [14:0] reg_addr_t;
	typedef logic [31:0] reg_data_t;
	typedef logic signed [31:0] enc_count_t;
	typedef logic [15:0] pwm_word_t;

	// one SPI command as seen by the register bank
	typedef struct packed {
		logic      rw;
		reg_addr_t addr;
		reg_data_t wdata;
	} spi_cmd_t;

	// motor channel drive settings
	typedef struct packed {
		logic      enable;
		logic      brake;
		logic      drv_off;
		pwm_word_t period;
		pwm_word_t duty;
	} motor_ctrl_t;

	typedef struct packed {
		enc_count_t  count;
		logic [15:0] errors;
	} enc_status_t;

	typedef enum logic [2:0] {
		LINK_IDLE,
		LINK_ADDR,
		LINK_WAIT_RD,
		LINK_DATA,
		LINK_WAIT_WR
	} link_state_t;

	//////////////////////////////////////////////////
	// register map
	//////////////////////////////////////////////////
	localparam reg_addr_t ADDR_VERSION         = 15'h0000;
	localparam reg_addr_t ADDR_DIP_SWITCH      = 15'h0002;
	localparam reg_addr_t ADDR_ENC_COUNT       = 15'h0010;
	localparam reg_addr_t ADDR_ENC_ERROR       = 15'h0011;
	localparam reg_addr_t ADDR_PWM_CYCLE       = 15'h0012;
	localparam reg_addr_t ADDR_MOTION_CONTROL  = 15'h0013;
	localparam reg_addr_t ADDR_DRIVER_FEEDBACK = 15'h0014;
	localparam reg_addr_t ADDR_DIAG_LEDS       = 15'h0020;

	// bit positions inside motion control and feedback
	localparam int MC_ENABLE  = 0;
	localparam int MC_BRAKE   = 1;
	localparam int MC_DRV_OFF = 2;
	localparam int FB_NFAULT  = 0;
	localparam int FB_FGOUT   = 1;

	localparam reg_data_t READ_MISS_VALUE = '1;
	localparam int FRAME_BITS = 48;

endpackage

/* logic/spi_slave_link.sv */
// SPI mode 0 slave that splits 48-bit frames into bank commands and serves read data
`timescale 1ns/100ps

module spi_slave_link import fpga_4mb_pkg::*; #(
	parameter int SYNC_STAGES = 2
) (
	input  logic      clk_100m,
	input  logic      Master_rstn,
	input  logic      sclk,
	input  logic      mosi,
	input  logic      cs_n,
	output logic      miso,
	output spi_cmd_t  cmd,
	output logic      cmd_req,
	input  logic      cmd_ack,
	input  reg_data_t rd_data
);

	localparam int DATA_BITS = $bits(reg_data_t);
	localparam int HEAD_BITS = FRAME_BITS - DATA_BITS;
	localparam int CNT_W = $clog2(DATA_BITS) + 1;

	logic [SYNC_STAGES-1:0] sclk_sync;
	logic [SYNC_STAGES-1:0] mosi_sync;
	logic [SYNC_STAGES-1:0] cs_sync;
	logic sclk_d;
	logic cs_d;
	logic sclk_rise;
	logic sclk_fall;
	logic cs_fall;
	logic cs_high;
	logic mosi_s;
	link_state_t state;
	logic [CNT_W-1:0] bit_cnt;
	reg_data_t shreg;
	reg_data_t rx_word;

	//////////////////////////////////////////////////
	// pin synchronizers and edge detect
	//////////////////////////////////////////////////
	always_ff @(posedge clk_100m or negedge Master_rstn) begin
		if (!Master_rstn) begin
			sclk_sync <= '0;
			mosi_sync <= '0;
			cs_sync <= '1;
			sclk_d <= 1'b0;
			cs_d <= 1'b1;
		end else begin
			sclk_sync <= {sclk_sync[SYNC_STAGES-2:0], sclk};
			mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], mosi};
			cs_sync <= {cs_sync[SYNC_STAGES-2:0], cs_n};
			sclk_d <= sclk_sync[SYNC_STAGES-1];
			cs_d <= cs_sync[SYNC_STAGES-1];
		end
	end

	assign sclk_rise = sclk_sync[SYNC_STAGES-1] & ~sclk_d;
	assign sclk_fall = ~sclk_sync[SYNC_STAGES-1] & sclk_d;
	assign cs_high = cs_sync[SYNC_STAGES-1];
	assign cs_fall = cs_d & ~cs_high;
	assign mosi_s = mosi_sync[SYNC_STAGES-1];

	// shift register with the current mosi bit appended
	assign rx_word = {shreg[DATA_BITS-2:0], mosi_s};

	//////////////////////////////////////////////////
	// frame FSM that owns the req side of the handshake
	//////////////////////////////////////////////////
	always_ff @(posedge clk_100m or negedge Master_rstn) begin
		if (!Master_rstn) begin
			state <= LINK_IDLE;
			bit_cnt <= '0;
			shreg <= '0;
			cmd <= '0;
			cmd_req <= 1'b0;
			miso <= 1'b0;
		end else begin
			case (state)
				LINK_IDLE: begin
					miso <= 1'b0;
					bit_cnt <= '0;
					// new frame only on a fresh cs_n fall
					if (cs_fall)
						state <= LINK_ADDR;
				end
				LINK_ADDR: begin
					if (cs_high) begin
						state <= LINK_IDLE;
					end else if (sclk_rise) begin
						shreg <= rx_word;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == CNT_W'(HEAD_BITS - 1)) begin
							cmd.rw <= rx_word[HEAD_BITS-1];
							cmd.addr <= rx_word[HEAD_BITS-2:0];
							bit_cnt <= '0;
							if (rx_word[HEAD_BITS-1]) begin
								state <= LINK_DATA;
							end else begin
								// a read fetches the word before the data phase
								cmd_req <= 1'b1;
								state <= LINK_WAIT_RD;
							end
						end
					end
				end
				LINK_WAIT_RD: begin
					if (cmd_ack) begin
						cmd_req <= 1'b0;
						shreg <= rd_data;
						state <= cs_high ? LINK_IDLE : LINK_DATA;
					end
				end
				LINK_DATA: begin
					if (cs_high) begin
						miso <= 1'b0;
						state <= LINK_IDLE;
					end else if (sclk_rise) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (cmd.rw)
							shreg <= rx_word;
						if (bit_cnt == CNT_W'(DATA_BITS - 1)) begin
							miso <= 1'b0;
							if (cmd.rw) begin
								cmd.wdata <= rx_word;
								cmd_req <= 1'b1;
								state <= LINK_WAIT_WR;
							end else begin
								state <= LINK_IDLE;
							end
						end
					end else if (sclk_fall && !cmd.rw) begin
						// mode 0 puts the next bit out after the fall
						miso <= shreg[DATA_BITS-1];
						shreg <= {shreg[DATA_BITS-2:0], 1'b0};
					end
				end
				LINK_WAIT_WR: begin
					if (cmd_ack) begin
						cmd_req <= 1'b0;
						state <= LINK_IDLE;
					end
				end
				default: state <= LINK_IDLE;
			endcase
		end
	end

endmodule

/* logic/reg_bank.sv */
// register bank that acks link commands, holds the control registers and muxes read data
`timescale 1ns/100ps

module reg_bank import fpga_4mb_pkg::*; #(
	parameter reg_data_t FPGA_VERSION = '0
) (
	input  logic        clk_100m,
	input  logic        Master_rstn,
	input  spi_cmd_t    cmd,
	input  logic        cmd_req,
	output logic        cmd_ack,
	output reg_data_t   rd_data,
	input  enc_status_t enc_status,
	output logic        enc_load,
	output enc_count_t  enc_load_value,
	output motor_ctrl_t motor_ctrl,
	input  logic [3:0]  dipsw,
	input  logic        nfault,
	input  logic        fgout,
	output logic        led1_2
);

	logic [5:0] pin_meta;
	logic [5:0] pin_sync;
	logic [3:0] dip_s;
	logic nfault_s;
	logic fgout_s;
	reg_data_t pwm_cycle;
	reg_data_t diag_leds;
	logic [2:0] motion;
	logic access;
	reg_data_t rd_word;

	// slow board inputs through two flops
	always_ff @(posedge clk_100m or negedge Master_rstn) begin
		if (!Master_rstn) begin
			pin_meta <= '0;
			pin_sync <= '0;
		end else begin
			pin_meta <= {fgout, nfault, dipsw};
			pin_sync <= pin_meta;
		end
	end

	assign {fgout_s, nfault_s, dip_s} = pin_sync;

	// first cycle of a request before the ack goes out
	assign access = cmd_req & ~cmd_ack;

	//////////////////////////////////////////////////
	// handshake and register writes
	//////////////////////////////////////////////////
	always_ff @(posedge clk_100m or negedge Master_rstn) begin
		if (!Master_rstn) begin
			cmd_ack <= 1'b0;
			pwm_cycle <= '0;
			diag_leds <= '0;
			motion <= 3'b100;
			enc_load <= 1'b0;
			enc_load_value <= '0;
		end else begin
			cmd_ack <= cmd_req;
			enc_load <= 1'b0;
			if (access && cmd.rw) begin
				case (cmd.addr)
					ADDR_PWM_CYCLE: pwm_cycle <= cmd.wdata;
					ADDR_MOTION_CONTROL: motion <= cmd.wdata[2:0];
					ADDR_DIAG_LEDS: diag_leds <= cmd.wdata;
					ADDR_ENC_COUNT: begin
						enc_load <= 1'b1;
						enc_load_value <= cmd.wdata;
					end
					// error clear rides on the load path
					ADDR_ENC_ERROR: begin
						enc_load <= 1'b1;
						enc_load_value <= '0;
					end
					default: ;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// read mux
	//////////////////////////////////////////////////
	always_comb begin
		case (cmd.addr)
			ADDR_VERSION: rd_word = FPGA_VERSION;
			ADDR_DIP_SWITCH: rd_word = {28'd0, dip_s};
			ADDR_ENC_COUNT: rd_word = enc_status.count;
			ADDR_ENC_ERROR: rd_word = {16'd0, enc_status.errors};
			ADDR_PWM_CYCLE: rd_word = pwm_cycle;
			ADDR_MOTION_CONTROL: rd_word = {29'd0, motion};
			ADDR_DRIVER_FEEDBACK: rd_word = {30'd0, fgout_s, nfault_s};
			ADDR_DIAG_LEDS: rd_word = diag_leds;
			default: rd_word = READ_MISS_VALUE;
		endcase
	end

	// valid together with the ack
	always_ff @(posedge clk_100m) begin
		if (access && !cmd.rw)
			rd_data <= rd_word;
	end

	assign motor_ctrl = '{
		enable: motion[MC_ENABLE],
		brake: motion[MC_BRAKE],
		drv_off: motion[MC_DRV_OFF],
		period: pwm_cycle[31:16],
		duty: pwm_cycle[15:0]
	};

	assign led1_2 = diag_leds[0];

endmodule

/* logic/quad_encoder.sv */
// quadrature decoder giving a signed position count and a saturating illegal-transition count
`timescale 1ns/100ps

module quad_encoder import fpga_4mb_pkg::*; #(
	parameter int SYNC_STAGES = 2
) (
	input  logic        clk_100m,
	input  logic        Master_rstn,
	input  logic        qca,
	input  logic        qcb,
	input  logic        enc_load,
	input  enc_count_t  enc_load_value,
	output enc_status_t enc_status
);

	logic [SYNC_STAGES-1:0] a_sync;
	logic [SYNC_STAGES-1:0] b_sync;
	logic [1:0] ab_cur;
	logic [1:0] ab_prev;
	logic [1:0] ab_diff;
	logic step;
	logic up;
	logic illegal;

	always_ff @(posedge clk_100m or negedge Master_rstn) begin
		if (!Master_rstn) begin
			a_sync <= '0;
			b_sync <= '0;
			ab_prev <= 2'b00;
		end else begin
			a_sync <= {a_sync[SYNC_STAGES-2:0], qca};
			b_sync <= {b_sync[SYNC_STAGES-2:0], qcb};
			ab_prev <= ab_cur;
		end
	end

	assign ab_cur = {a_sync[SYNC_STAGES-1], b_sync[SYNC_STAGES-1]};
	assign ab_diff = ab_cur ^ ab_prev;

	// one line moved is a step, both lines at once is an error
	assign step = ^ab_diff;
	assign illegal = &ab_diff;
	// A leading B gives new A != old B
	assign up = ab_cur[1] ^ ab_prev[0];

	always_ff @(posedge clk_100m or negedge Master_rstn) begin
		if (!Master_rstn) begin
			enc_status <= '0;
		end else if (enc_load) begin
			enc_status.count <= enc_load_value;
			enc_status.errors <= '0;
		end else if (step) begin
			enc_status.count <= up ? enc_status.count + 1 : enc_status.count - 1;
		end else if (illegal && enc_status.errors != '1) begin
			enc_status.errors <= enc_status.errors + 1'b1;
		end
	end

endmodule

/* logic/pwm_drive.sv */
// PWM generator with wrap-aligned period/duty update; registers the brake and driver-off pins
`timescale 1ns/100ps

module pwm_drive import fpga_4mb_pkg::*; (
	input  logic        clk_100m,
	input  logic        Master_rstn,
	input  motor_ctrl_t motor_ctrl,
	output logic        pwm,
	output logic        brake,
	output logic        droff
);

	pwm_word_t cnt;
	pwm_word_t period_q;
	pwm_word_t duty_q;
	logic wrap;

	// zero period wraps every cycle so a new setting is picked up at once
	assign wrap = (period_q == '0) || (cnt == period_q - 1'b1);

	always_ff @(posedge clk_100m or negedge Master_rstn) begin
		if (!Master_rstn) begin
			cnt <= '0;
			period_q <= '0;
			duty_q <= '0;
			pwm <= 1'b0;
			brake <= 1'b0;
			droff <= 1'b1;
		end else begin
			if (wrap) begin
				cnt <= '0;
				period_q <= motor_ctrl.period;
				duty_q <= motor_ctrl.duty;
			end else begin
				cnt <= cnt + 1'b1;
			end
			pwm <= motor_ctrl.enable && (cnt < duty_q);
			brake <= motor_ctrl.brake;
			droff <= motor_ctrl.drv_off;
		end
	end

endmodule

/* logic/heartbeat_led.sv */
// heartbeat that divides the system clock and toggles the diagnostic LED
`timescale 1ns/100ps

module heartbeat_led #(
	parameter int unsigned BLINK_HALF_CYCLES = 5_000_000
) (
	input  logic clk_100m,
	input  logic Master_rstn,
	output logic led1_1
);

	localparam int CNT_W = (BLINK_HALF_CYCLES > 1) ? $clog2(BLINK_HALF_CYCLES) : 1;

	logic [CNT_W-1:0] div_cnt;

	always_ff @(posedge clk_100m or negedge Master_rstn) begin
		if (!Master_rstn) begin
			div_cnt <= '0;
			led1_1 <= 1'b0;
		end else if (div_cnt == CNT_W'(BLINK_HALF_CYCLES - 1)) begin
			div_cnt <= '0;
			led1_1 <= ~led1_1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

endmodule

/* logic/top_4mb.sv */
// motor board FPGA top level with the SPI link, register bank, one motor channel and the heartbeat
`timescale 1ns/100ps

module top_4mb import fpga_4mb_pkg::*; #(
	parameter reg_data_t FPGA_VERSION = 32'h0004_0100,
	parameter int unsigned BLINK_HALF_CYCLES = 5_000_000,
	parameter int SYNC_STAGES = 2
) (
	input  logic       clk_100m,
	input  logic       Master_rstn,
	// host SPI
	input  logic       mclk_0,
	input  logic       mosi_0,
	output logic       miso_0,
	input  logic       cs_00,
	// motor 1
	input  logic       qc1a,
	input  logic       qc1b,
	input  logic       nfault1,
	input  logic       fgout1,
	output logic       pwm1,
	output logic       brake1,
	output logic       droff1,
	// board
	input  logic [3:0] dipsw,
	output logic       led1_1,
	output logic       led1_2
);

	spi_cmd_t cmd;
	logic cmd_req;
	logic cmd_ack;
	reg_data_t rd_data;
	enc_status_t enc_status;
	logic enc_load;
	enc_count_t enc_load_value;
	motor_ctrl_t motor_ctrl;

	//////////////////////////////////////////////////
	// command path
	//////////////////////////////////////////////////
	spi_slave_link #(
		.SYNC_STAGES(SYNC_STAGES)
	) u_link (
		.clk_100m(clk_100m),
		.Master_rstn(Master_rstn),
		.sclk(mclk_0),
		.mosi(mosi_0),
		.cs_n(cs_00),
		.miso(miso_0),
		.cmd(cmd),
		.cmd_req(cmd_req),
		.cmd_ack(cmd_ack),
		.rd_data(rd_data)
	);

	reg_bank #(
		.FPGA_VERSION(FPGA_VERSION)
	) u_regs (
		.clk_100m(clk_100m),
		.Master_rstn(Master_rstn),
		.cmd(cmd),
		.cmd_req(cmd_req),
		.cmd_ack(cmd_ack),
		.rd_data(rd_data),
		.enc_status(enc_status),
		.enc_load(enc_load),
		.enc_load_value(enc_load_value),
		.motor_ctrl(motor_ctrl),
		.dipsw(dipsw),
		.nfault(nfault1),
		.fgout(fgout1),
		.led1_2(led1_2)
	);

	//////////////////////////////////////////////////
	// motor channel 1
	//////////////////////////////////////////////////
	quad_encoder #(
		.SYNC_STAGES(SYNC_STAGES)
	) u_enc1 (
		.clk_100m(clk_100m),
		.Master_rstn(Master_rstn),
		.qca(qc1a),
		.qcb(qc1b),
		.enc_load(enc_load),
		.enc_load_value(enc_load_value),
		.enc_status(enc_status)
	);

	pwm_drive u_pwm1 (
		.clk_100m(clk_100m),
		.Master_rstn(Master_rstn),
		.motor_ctrl(motor_ctrl),
		.pwm(pwm1),
		.brake(brake1),
		.droff(droff1)
	);

	heartbeat_led #(
		.BLINK_HALF_CYCLES(BLINK_HALF_CYCLES)
	) u_heartbeat (
		.clk_100m(clk_100m),
		.Master_rstn(Master_rstn),
		.led1_1(led1_1)
	);

endmodule

/* sim/tb_spi_bfm.svh */
// SPI mode 0 master tasks for the motor board testbench; include inside the testbench module
`ifndef TB_SPI_BFM_SVH
`define TB_SPI_BFM_SVH

// 80 ns high and low at 10 ns per clock
localparam int SCLK_HALF_CYCLES = 8;
localparam int HANDSHAKE_TIMEOUT = 64;

// advance n clocks, then step past the edge for driving
task automatic step_cycles(input int n);
	repeat (n) @(posedge clk_100m);
	#1;
endtask

// one 48-bit frame sent MSB first with the read word coming back on the data phase
task automatic spi_transfer(input logic rw, input reg_addr_t addr, input reg_data_t wdata,
		output reg_data_t rdata);
	logic [FRAME_BITS-1:0] frame;
	int wait_cnt;
	frame = {rw, addr, wdata};
	rdata = '0;
	wait_cnt = 0;
	// gap with cs_n high between frames
	step_cycles(SCLK_HALF_CYCLES);
	cs_00 = 1'b0;
	for (int i = FRAME_BITS - 1; i >= 0; i--) begin
		mosi_0 = frame[i];
		step_cycles(SCLK_HALF_CYCLES);
		// master samples miso just before the rising edge
		if (i < $bits(reg_data_t))
			rdata = {rdata[$bits(reg_data_t)-2:0], miso_0};
		mclk_0 = 1'b1;
		step_cycles(SCLK_HALF_CYCLES);
		mclk_0 = 1'b0;
	end
	mosi_0 = 1'b0;
	step_cycles(SCLK_HALF_CYCLES);
	// req/ack must be back at rest before the frame closes
	while ((DUT.cmd_req || DUT.cmd_ack) && wait_cnt < HANDSHAKE_TIMEOUT) begin
		step_cycles(1);
		wait_cnt++;
	end
	if (DUT.cmd_req || DUT.cmd_ack)
		abort_run("the link to bank handshake did not return to idle after a frame");
	cs_00 = 1'b1;
endtask

task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
	reg_data_t discard;
	spi_transfer(1'b1, addr, data, discard);
endtask

task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
	spi_transfer(1'b0, addr, '0, data);
endtask

`endif

/* sim/tb_top_4mb.sv */
// directed testbench for the motor board top that drives SPI, encoder and board pins
`timescale 1ns/100ps

module tb_top_4mb import fpga_4mb_pkg::*; ();

	localparam reg_data_t EXP_VERSION = 32'h0004_0100;
	localparam int BLINK_HALF = 20;
	localparam reg_addr_t UNMAPPED_ADDR = 15'h0100;
	localparam int QUAD_GAP_CYCLES = 10;
	localparam int PWM_SETTLE_TIMEOUT = 1000;
	localparam int TOGGLE_TIMEOUT = 100;

	logic clk_100m = 1'b0;
	logic Master_rstn;
	logic mclk_0;
	logic mosi_0;
	logic miso_0;
	logic cs_00;
	logic qc1a;
	logic qc1b;
	logic nfault1;
	logic fgout1;
	logic [3:0] dipsw;
	logic pwm1;
	logic brake1;
	logic droff1;
	logic led1_1;
	logic led1_2;

	int errors = 0;
	int checks = 0;
	int quad_pos = 0;
	int unsigned seed;

	`include "tb_spi_bfm.svh"

	always #5 clk_100m = ~clk_100m;

	top_4mb #(
		.FPGA_VERSION(EXP_VERSION),
		.BLINK_HALF_CYCLES(BLINK_HALF)
	) DUT (
		.clk_100m(clk_100m),
		.Master_rstn(Master_rstn),
		.mclk_0(mclk_0),
		.mosi_0(mosi_0),
		.miso_0(miso_0),
		.cs_00(cs_00),
		.qc1a(qc1a),
		.qc1b(qc1b),
		.nfault1(nfault1),
		.fgout1(fgout1),
		.dipsw(dipsw),
		.pwm1(pwm1),
		.brake1(brake1),
		.droff1(droff1),
		.led1_1(led1_1),
		.led1_2(led1_2)
	);

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$finish;
	endtask

	task automatic check_word(input string what, input reg_data_t got, input reg_data_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic end_test(input string name, input int errors_before);
		if (errors == errors_before)
			$display("%s: ok", name);
		else
			$display("%s: failed with %0d errors", name, errors - errors_before);
	endtask

	// gray sequence with A leading B going forward
	function automatic logic [1:0] quad_state(input int idx);
		case (idx & 3)
			0: return 2'b00;
			1: return 2'b10;
			2: return 2'b11;
			default: return 2'b01;
		endcase
	endfunction

	// dir of +2 flips both lines at once
	task automatic quad_move(input int dir);
		quad_pos = (quad_pos + dir) & 3;
		{qc1a, qc1b} = quad_state(quad_pos);
		step_cycles(QUAD_GAP_CYCLES);
	endtask

	task automatic cycles_to_toggle(output int n);
		logic prev;
		prev = led1_1;
		n = 0;
		while (led1_1 === prev && n < TOGGLE_TIMEOUT) begin
			step_cycles(1);
			n++;
		end
		if (led1_1 === prev)
			abort_run("the heartbeat LED stopped toggling");
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////
	task automatic reset_and_identity();
		int errors_before;
		reg_data_t rd;
		errors_before = errors;
		check_word("pwm1 after reset", {31'd0, pwm1}, 32'd0);
		check_word("brake1 after reset", {31'd0, brake1}, 32'd0);
		check_word("droff1 after reset", {31'd0, droff1}, 32'd1);
		reg_read(ADDR_VERSION, rd);
		check_word("version register", rd, EXP_VERSION);
		reg_read(ADDR_DIP_SWITCH, rd);
		check_word("dip switch register", rd, {28'd0, dipsw});
		end_test("reset and identity", errors_before);
	endtask

	task automatic register_access();
		int errors_before;
		reg_data_t rd;
		reg_data_t cyc_word;
		reg_data_t led_word;
		errors_before = errors;
		// short period field so the PWM test settles fast
		cyc_word = $urandom & 32'h00ff_ffff;
		reg_write(ADDR_PWM_CYCLE, cyc_word);
		reg_read(ADDR_PWM_CYCLE, rd);
		check_word("pwm cycle readback", rd, cyc_word);
		led_word = $urandom;
		for (int k = 0; k < 2; k++) begin
			reg_write(ADDR_DIAG_LEDS, led_word);
			reg_read(ADDR_DIAG_LEDS, rd);
			check_word("diag leds readback", rd, led_word);
			check_word("led1_2 pin", {31'd0, led1_2}, {31'd0, led_word[0]});
			led_word[0] = ~led_word[0];
		end
		led_word[0] = ~led_word[0];
		reg_read(UNMAPPED_ADDR, rd);
		check_word("unmapped read", rd, 32'hffff_ffff);
		reg_write(UNMAPPED_ADDR, $urandom);
		reg_read(ADDR_PWM_CYCLE, rd);
		check_word("pwm cycle after unmapped write", rd, cyc_word);
		reg_read(ADDR_DIAG_LEDS, rd);
		check_word("diag leds after unmapped write", rd, led_word);
		reg_read(ADDR_MOTION_CONTROL, rd);
		check_word("motion control after unmapped write", rd, 32'h0000_0004);
		end_test("register access", errors_before);
	endtask

	task automatic pwm_output();
		int errors_before;
		int period;
		int duty;
		int wait_cnt;
		int high_cnt;
		logic prev;
		errors_before = errors;
		period = 8 + $urandom % 120;
		duty = 1 + $urandom % (period - 1);
		reg_write(ADDR_PWM_CYCLE, {16'(period), 16'(duty)});
		// new period is latched during this frame
		reg_write(ADDR_MOTION_CONTROL, 32'h0000_0005);
		wait_cnt = 0;
		prev = pwm1;
		while (!(pwm1 && !prev) && wait_cnt < PWM_SETTLE_TIMEOUT) begin
			prev = pwm1;
			step_cycles(1);
			wait_cnt++;
		end
		if (!(pwm1 && !prev))
			abort_run("pwm1 never started a new period after enable");
		high_cnt = 0;
		for (int k = 0; k < 4 * period; k++) begin
			if (pwm1)
				high_cnt++;
			step_cycles(1);
		end
		check_word("pwm high cycles over 4 periods", high_cnt, 4 * duty);
		// brake on and driver on within 8 cycles of cs_n high
		reg_write(ADDR_MOTION_CONTROL, 32'h0000_0003);
		wait_cnt = 0;
		while (!(brake1 === 1'b1 && droff1 === 1'b0) && wait_cnt < 8) begin
			step_cycles(1);
			wait_cnt++;
		end
		check_word("brake1 pin", {31'd0, brake1}, 32'd1);
		check_word("droff1 pin", {31'd0, droff1}, 32'd0);
		reg_write(ADDR_MOTION_CONTROL, 32'h0000_0002);
		high_cnt = 0;
		for (int k = 0; k < 2 * period; k++) begin
			if (pwm1 !== 1'b0)
				high_cnt++;
			step_cycles(1);
		end
		check_word("pwm high cycles while disabled", high_cnt, 32'd0);
		reg_write(ADDR_MOTION_CONTROL, 32'h0000_0004);
		end_test("pwm output", errors_before);
	endtask

	task automatic encoder_counting();
		int errors_before;
		int fwd_steps;
		int rev_steps;
		enc_count_t expect_count;
		reg_data_t rd;
		reg_data_t load_val;
		errors_before = errors;
		fwd_steps = 20 + $urandom % 30;
		rev_steps = $urandom % (fwd_steps + 10);
		repeat (fwd_steps) quad_move(1);
		repeat (rev_steps) quad_move(-1);
		expect_count = fwd_steps - rev_steps;
		reg_read(ADDR_ENC_COUNT, rd);
		check_word("encoder count", rd, expect_count);
		// only legal steps so far
		reg_read(ADDR_ENC_ERROR, rd);
		check_word("encoder errors before double transition", rd, 32'd0);
		quad_move(2);
		reg_read(ADDR_ENC_ERROR, rd);
		check_word("encoder errors after double transition", rd, 32'd1);
		reg_read(ADDR_ENC_COUNT, rd);
		check_word("encoder count after double transition", rd, expect_count);
		load_val = $urandom;
		reg_write(ADDR_ENC_COUNT, load_val);
		reg_read(ADDR_ENC_COUNT, rd);
		check_word("encoder count after load", rd, load_val);
		// a new double transition gives the clear something to remove
		quad_move(2);
		reg_read(ADDR_ENC_ERROR, rd);
		check_word("encoder errors before clear", rd, 32'd1);
		// error clear also loads a zero count
		reg_write(ADDR_ENC_ERROR, $urandom);
		reg_read(ADDR_ENC_ERROR, rd);
		check_word("encoder errors after clear", rd, 32'd0);
		reg_read(ADDR_ENC_COUNT, rd);
		check_word("encoder count after error clear", rd, 32'd0);
		end_test("encoder counting", errors_before);
	endtask

	task automatic heartbeat_and_feedback();
		int errors_before;
		int n;
		reg_data_t rd;
		errors_before = errors;
		// align to a toggle first
		cycles_to_toggle(n);
		for (int k = 0; k < 3; k++) begin
			cycles_to_toggle(n);
			check_word("heartbeat half period", n, BLINK_HALF);
		end
		for (int k = 0; k < 4; k++) begin
			nfault1 = k[0];
			fgout1 = k[1];
			step_cycles(4);
			reg_read(ADDR_DRIVER_FEEDBACK, rd);
			check_word("driver feedback", rd, {30'd0, fgout1, nfault1});
		end
		end_test("heartbeat and feedback", errors_before);
	endtask

	//////////////////////////////////////////////////
	// run
	//////////////////////////////////////////////////
	initial begin
		seed = 32'h79a8_9ff0;
		void'($urandom(seed));
		Master_rstn = 1'b0;
		mclk_0 = 1'b0;
		mosi_0 = 1'b0;
		cs_00 = 1'b1;
		qc1a = 1'b0;
		qc1b = 1'b0;
		nfault1 = 1'b0;
		fgout1 = 1'b0;
		dipsw = 4'($urandom);
		repeat (2) @(posedge clk_100m);
		#1;
		Master_rstn = 1'b1;
		step_cycles(2);

		reset_and_identity();
		register_access();
		pwm_output();
		encoder_counting();
		heartbeat_and_feedback();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+sim
logic/fpga_4mb_pkg.sv
logic/spi_slave_link.sv
logic/reg_bank.sv
logic/quad_encoder.sv
logic/pwm_drive.sv
logic/heartbeat_led.sv
logic/top_4mb.sv
sim/tb_top_4mb.sv
